/* design/timer_macros.svh */
////////////////////////////////////////////////////////////
// interval timer bank sizing and reset values
////////////////////////////////////////////////////////////

`ifndef TIMER_MACROS_SVH
`define TIMER_MACROS_SVH

// number of timer cores behind one bank
`define TIMER_NUM_CORES 4

// bus data width of one register half
`define TIMER_DATA_WIDTH 16

// register address inside one core and the core index above it
`define TIMER_REG_ADDR_WIDTH 3
`define TIMER_CORE_SEL_WIDTH 2

// period low and counter come out of reset at the same value
`define TIMER_RESET_PERIOD_L 19999
`define TIMER_RESET_COUNT 32'h4E1F

`endif

/* design/timer_regs_pkg.sv */
////////////////////////////////////////////////////////////
// timer register map and control/status bit positions
////////////////////////////////////////////////////////////

`include "timer_macros.svh"

package timer_regs_pkg;

  // register offsets inside one timer core
  typedef enum logic [`TIMER_REG_ADDR_WIDTH-1:0] {
    reg_status   = 3'd0,
    reg_control  = 3'd1,
    reg_period_l = 3'd2,
    reg_period_h = 3'd3,
    reg_snap_l   = 3'd4,
    reg_snap_h   = 3'd5
  } timer_reg_e;

  // only the low bits of the control register are stored
  localparam int unsigned ctrl_width     = 4;
  localparam int unsigned ctrl_ito_bit   = 0;
  localparam int unsigned ctrl_cont_bit  = 1;
  localparam int unsigned ctrl_start_bit = 2;
  localparam int unsigned ctrl_stop_bit  = 3;

  localparam int unsigned status_to_bit  = 0;
  localparam int unsigned status_run_bit = 1;

endpackage

/* design/timer_count_pkg.sv */
////////////////////////////////////////////////////////////
// timer down counter width and run state
////////////////////////////////////////////////////////////

`include "timer_macros.svh"

package timer_count_pkg;

  // the counter spans the period low and high halves
  localparam int unsigned count_width = 2 * `TIMER_DATA_WIDTH;

  // run state of the down counter
  typedef enum logic {
    cnt_stopped = 1'b0,
    cnt_running = 1'b1
  } timer_run_e;

endpackage

/* design/timer_counter.sv */
////////////////////////////////////////////////////////////
// timer down counter with reload, run state and
// timeout pulse on the first cycle at zero
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "timer_macros.svh"

module timer_counter
  import timer_count_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic [count_width-1:0] load_value,
  input  logic                   force_reload,
  input  logic                   start,
  input  logic                   stop,
  input  logic                   continuous,
  output logic [count_width-1:0] count,
  output timer_run_e             run_state,
  output logic                   timeout_event
);

  logic count_is_zero;
  logic zero_dly;
  logic do_stop;
  logic counting;

  assign count_is_zero = (count == '0);
  assign counting      = (run_state == cnt_running);

  // a period write, a stop request or the end of a one-shot run stops the count
  assign do_stop = stop || force_reload || (count_is_zero && !continuous);

  // the count only moves while running, except that a forced reload always lands
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      count <= `TIMER_RESET_COUNT;
    end
    else if (counting || force_reload)
    begin
      if (count_is_zero || force_reload)
      begin
        count <= load_value;
      end
      else
      begin
        count <= count - 1'b1;
      end
    end
  end

  // start has priority so a combined start and stop write keeps it running
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      run_state <= cnt_stopped;
    end
    else if (start)
    begin
      run_state <= cnt_running;
    end
    else if (do_stop)
    begin
      run_state <= cnt_stopped;
    end
  end

  // the zero compare of the previous cycle marks the rising edge
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      zero_dly <= 1'b0;
    end
    else
    begin
      zero_dly <= count_is_zero;
    end
  end

  // only one pulse per arrival at zero even if the count lingers there
  assign timeout_event = count_is_zero && !zero_dly;

endmodule

/* design/timer_core.sv */
////////////////////////////////////////////////////////////
// one interval timer: register file, snapshot, read mux,
// timeout flag and interrupt chain
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "timer_macros.svh"

module timer_core
  import timer_regs_pkg::*;
  import timer_count_pkg::*;
(
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic [`TIMER_REG_ADDR_WIDTH-1:0] address,
  input  logic                             chipselect,
  input  logic                             write_n,
  input  logic [`TIMER_DATA_WIDTH-1:0]     writedata,
  output logic [`TIMER_DATA_WIDTH-1:0]     readdata,
  input  logic                             irq_chain_in,
  output logic                             irq,
  output logic                             irq_chain_out
);

  timer_reg_e                   reg_addr;
  logic                         wr_en;
  logic                         status_wr;
  logic                         control_wr;
  logic                         period_l_wr;
  logic                         period_h_wr;
  logic                         snap_wr;
  logic [ctrl_width-1:0]        ctrl_reg;
  logic [`TIMER_DATA_WIDTH-1:0] period_l;
  logic [`TIMER_DATA_WIDTH-1:0] period_h;
  logic [count_width-1:0]       snapshot;
  logic [count_width-1:0]       count;
  logic                         force_reload;
  logic                         start;
  logic                         stop;
  timer_run_e                   run_state;
  logic                         timeout_event;
  logic                         timeout_flag;
  logic [`TIMER_DATA_WIDTH-1:0] status_word;
  logic [`TIMER_DATA_WIDTH-1:0] read_mux;

  assign reg_addr = timer_reg_e'(address);
  assign wr_en    = chipselect && !write_n;

  // per-register write strobes
  assign status_wr   = wr_en && (reg_addr == reg_status);
  assign control_wr  = wr_en && (reg_addr == reg_control);
  assign period_l_wr = wr_en && (reg_addr == reg_period_l);
  assign period_h_wr = wr_en && (reg_addr == reg_period_h);
  assign snap_wr     = wr_en && ((reg_addr == reg_snap_l) || (reg_addr == reg_snap_h));

  // start and stop act on the write itself, not on the stored bits
  assign start = control_wr && writedata[ctrl_start_bit];
  assign stop  = control_wr && writedata[ctrl_stop_bit];

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      ctrl_reg     <= '0;
      period_l     <= `TIMER_RESET_PERIOD_L;
      period_h     <= '0;
      snapshot     <= '0;
      force_reload <= 1'b0;
    end
    else
    begin
      if (control_wr)
        ctrl_reg <= writedata[ctrl_width-1:0];
      if (period_l_wr)
        period_l <= writedata;
      if (period_h_wr)
        period_h <= writedata;
      // a write to either snapshot half captures the whole live count
      if (snap_wr)
        snapshot <= count;
      force_reload <= period_l_wr || period_h_wr;
    end
  end

  timer_counter counter_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .load_value    ({period_h, period_l}),
    .force_reload  (force_reload),
    .start         (start),
    .stop          (stop),
    .continuous    (ctrl_reg[ctrl_cont_bit]),
    .count         (count),
    .run_state     (run_state),
    .timeout_event (timeout_event)
  );

  // clearing by a status write wins over a new timeout in the same cycle
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      timeout_flag <= 1'b0;
    else if (status_wr)
      timeout_flag <= 1'b0;
    else if (timeout_event || irq_chain_in)
      timeout_flag <= 1'b1;
  end

  always_comb
  begin
    status_word                 = '0;
    status_word[status_to_bit]  = timeout_flag;
    status_word[status_run_bit] = (run_state == cnt_running);
  end

  always_comb
  begin
    case (reg_addr)
      reg_status:   read_mux = status_word;
      reg_control:  read_mux = {{(`TIMER_DATA_WIDTH-ctrl_width){1'b0}}, ctrl_reg};
      reg_period_l: read_mux = period_l;
      reg_period_h: read_mux = period_h;
      reg_snap_l:   read_mux = snapshot[`TIMER_DATA_WIDTH-1:0];
      reg_snap_h:   read_mux = snapshot[count_width-1:`TIMER_DATA_WIDTH];
      default:      read_mux = '0;
    endcase
  end

  // read data follows the address one clock later
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      readdata <= '0;
    else
      readdata <= read_mux;
  end

  assign irq           = timeout_flag && ctrl_reg[ctrl_ito_bit];
  assign irq_chain_out = irq;

endmodule

/* design/timer_bank.sv */
////////////////////////////////////////////////////////////
// bank of interval timers with core index decode,
// read data select and a daisy-chained interrupt
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "timer_macros.svh"

module timer_bank (
  input  logic                                                   clk,
  input  logic                                                   reset_n,
  input  logic [`TIMER_CORE_SEL_WIDTH+`TIMER_REG_ADDR_WIDTH-1:0] address,
  input  logic                                                   chipselect,
  input  logic                                                   write_n,
  input  logic [`TIMER_DATA_WIDTH-1:0]                           writedata,
  output logic [`TIMER_DATA_WIDTH-1:0]                           readdata,
  input  logic                                                   irq_chain_in,
  output logic [`TIMER_NUM_CORES-1:0]                            irq,
  output logic                                                   irq_chain_out
);

  logic [`TIMER_CORE_SEL_WIDTH-1:0] core_sel;
  logic [`TIMER_CORE_SEL_WIDTH-1:0] core_sel_q;
  logic [`TIMER_REG_ADDR_WIDTH-1:0] reg_addr;
  logic [`TIMER_NUM_CORES-1:0]      core_cs;
  logic [`TIMER_DATA_WIDTH-1:0]     core_rdata [`TIMER_NUM_CORES];

  // chain[i] enters core i, chain[TIMER_NUM_CORES] leaves the bank
  logic [`TIMER_NUM_CORES:0]        chain;

  // core index sits above the register offset
  assign core_sel = address[`TIMER_CORE_SEL_WIDTH+`TIMER_REG_ADDR_WIDTH-1:`TIMER_REG_ADDR_WIDTH];
  assign reg_addr = address[`TIMER_REG_ADDR_WIDTH-1:0];

  assign chain[0]      = irq_chain_in;
  assign irq_chain_out = chain[`TIMER_NUM_CORES];

  genvar i;
  generate
    for (i = 0; i < `TIMER_NUM_CORES; i++)
    begin : g_core
      assign core_cs[i] = chipselect && (core_sel == `TIMER_CORE_SEL_WIDTH'(i));

      timer_core core_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .address       (reg_addr),
        .chipselect    (core_cs[i]),
        .write_n       (write_n),
        .writedata     (writedata),
        .readdata      (core_rdata[i]),
        .irq_chain_in  (chain[i]),
        .irq           (irq[i]),
        .irq_chain_out (chain[i+1])
      );
    end
  endgenerate

  // every core registers its read mux each cycle, so the index
  // is registered alongside to pick the matching word
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      core_sel_q <= '0;
    end
    else
    begin
      core_sel_q <= core_sel;
    end
  end

  assign readdata = core_rdata[core_sel_q];

endmodule

/* testbench/timer_bank_tb.sv */
////////////////////////////////////////////////////////////
// testbench for the interval timer bank with a register model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "timer_macros.svh"

module timer_bank_tb
  import timer_regs_pkg::*;
();

  localparam int num_cores  = `TIMER_NUM_CORES;
  localparam int clk_period = 40;
  // cycle budget per test in the order reset, reset values, registers, one-shot,
  // continuous, snapshot and chain
  localparam int test_cycles     = 5 + 100 + 140 + 120 + 200 + 40 + 260;
  localparam int watchdog_cycles = test_cycles + 500;

  logic                                                   clk = 1'b0;
  logic                                                   reset_n;
  logic [`TIMER_CORE_SEL_WIDTH+`TIMER_REG_ADDR_WIDTH-1:0] address;
  logic                                                   chipselect;
  logic                                                   write_n;
  logic [`TIMER_DATA_WIDTH-1:0]                           writedata;
  logic [`TIMER_DATA_WIDTH-1:0]                           readdata;
  logic                                                   irq_chain_in;
  logic [num_cores-1:0]                                   irq;
  logic                                                   irq_chain_out;

  // register model of every core
  logic [15:0] mdl_period_l [num_cores];
  logic [15:0] mdl_period_h [num_cores];
  logic [3:0]  mdl_ctrl     [num_cores];
  logic        mdl_flag     [num_cores];
  logic        mdl_run      [num_cores];
  logic [31:0] mdl_snap     [num_cores];
  logic        chain_level;

  // results waiting for the compare process
  string       name_q [$];
  logic [15:0] exp_q  [$];
  logic [15:0] act_q  [$];
  event        sample_ev;
  int          checks = 0;
  int          errors = 0;

  timer_bank dut_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .address       (address),
    .chipselect    (chipselect),
    .write_n       (write_n),
    .writedata     (writedata),
    .readdata      (readdata),
    .irq_chain_in  (irq_chain_in),
    .irq           (irq),
    .irq_chain_out (irq_chain_out)
  );

  always #(clk_period / 2) clk = ~clk;

  // a timeout flag also sets when the previous core forwards its masked interrupt
  task automatic propagate_chain();
    for (int i = 0; i < num_cores; i++)
    begin
      if ((i == 0) ? chain_level : (mdl_flag[i-1] && mdl_ctrl[i-1][ctrl_ito_bit]))
        mdl_flag[i] = 1'b1;
    end
  endtask

  function automatic logic [15:0] expected_read(input int c, input timer_reg_e r);
    logic [15:0] v;
    v = '0;
    case (r)
      reg_status:
      begin
        v[status_to_bit]  = mdl_flag[c];
        v[status_run_bit] = mdl_run[c];
      end
      reg_control:  v[3:0] = mdl_ctrl[c];
      reg_period_l: v = mdl_period_l[c];
      reg_period_h: v = mdl_period_h[c];
      reg_snap_l:   v = mdl_snap[c][15:0];
      reg_snap_h:   v = mdl_snap[c][31:16];
      default:      v = '0;
    endcase
    return v;
  endfunction

  function automatic logic [num_cores-1:0] expected_irq();
    logic [num_cores-1:0] v;
    for (int i = 0; i < num_cores; i++)
      v[i] = mdl_flag[i] && mdl_ctrl[i][ctrl_ito_bit];
    return v;
  endfunction

  task automatic update_model(input int c, input timer_reg_e r, input logic [15:0] data);
    case (r)
      reg_status: mdl_flag[c] = 1'b0;
      reg_control:
      begin
        mdl_ctrl[c] = data[3:0];
        // start beats stop when both bits are written together
        if (data[ctrl_start_bit])
          mdl_run[c] = 1'b1;
        else if (data[ctrl_stop_bit])
          mdl_run[c] = 1'b0;
      end
      reg_period_l:
      begin
        mdl_period_l[c] = data;
        mdl_run[c]      = 1'b0;
      end
      reg_period_h:
      begin
        mdl_period_h[c] = data;
        mdl_run[c]      = 1'b0;
      end
      // the counter sits at the period once a period write stopped it
      default: mdl_snap[c] = {mdl_period_h[c], mdl_period_l[c]};
    endcase
    propagate_chain();
  endtask

  task automatic expect_timeout(input int c);
    mdl_flag[c] = 1'b1;
    if (!mdl_ctrl[c][ctrl_cont_bit])
      mdl_run[c] = 1'b0;
    propagate_chain();
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic queue_result(input string name, input logic [15:0] exp_v,
                              input logic [15:0] act_v);
    name_q.push_back(name);
    exp_q.push_back(exp_v);
    act_q.push_back(act_v);
    -> sample_ev;
  endtask

  task automatic write_reg(input int c, input timer_reg_e r, input logic [15:0] data);
    @(posedge clk);
    address    <= {c[`TIMER_CORE_SEL_WIDTH-1:0], r};
    chipselect <= 1'b1;
    write_n    <= 1'b0;
    writedata  <= data;
    @(posedge clk);
    chipselect <= 1'b0;
    write_n    <= 1'b1;
    update_model(c, r, data);
  endtask

  task automatic read_check(input string test, input int c, input timer_reg_e r);
    logic [15:0] data;
    @(posedge clk);
    address    <= {c[`TIMER_CORE_SEL_WIDTH-1:0], r};
    chipselect <= 1'b1;
    write_n    <= 1'b1;
    // the core registers the word on this edge along with the bank's index
    @(posedge clk);
    @(negedge clk);
    data = readdata;
    queue_result($sformatf("%s core%0d %s", test, c, r.name()), expected_read(c, r), data);
  endtask

  task automatic check_irq(input string test);
    logic [num_cores-1:0] exp_irq;
    @(negedge clk);
    exp_irq = expected_irq();
    queue_result({test, " irq"}, 16'(exp_irq), 16'(irq));
    queue_result({test, " irq_chain_out"}, 16'(exp_irq[num_cores-1]), 16'(irq_chain_out));
  endtask

  task automatic read_all_status(input string test);
    for (int c = 0; c < num_cores; c++)
      read_check(test, c, reg_status);
  endtask

  // stop every counter, mask every interrupt and clear every timeout flag
  task automatic quiesce_cores();
    for (int c = 0; c < num_cores; c++)
      write_reg(c, reg_control, 16'd1 << ctrl_stop_bit);
    for (int c = 0; c < num_cores; c++)
      write_reg(c, reg_status, 16'h0000);
  endtask

  task automatic load_short_period(input int c, input int p);
    write_reg(c, reg_period_h, 16'h0000);
    write_reg(c, reg_period_l, 16'(p));
  endtask

  task automatic test_reset_values();
    for (int c = 0; c < num_cores; c++)
      for (int j = 0; j < 6; j++)
        read_check("reset", c, timer_reg_e'(j));
    check_irq("reset");
  endtask

  task automatic test_register_access();
    int         c;
    int         sel;
    timer_reg_e r;
    repeat (12)
    begin
      c   = $urandom_range(num_cores - 1, 0);
      sel = $urandom_range(2, 0);
      case (sel)
        0:       r = reg_period_l;
        1:       r = reg_period_h;
        default: r = reg_control;
      endcase
      write_reg(c, r, 16'($urandom));
      read_check("regs", c, r);
    end
    // every core, written or not, must still hold its own values
    for (int i = 0; i < num_cores; i++)
    begin
      read_check("regs keep", i, reg_period_l);
      read_check("regs keep", i, reg_period_h);
      read_check("regs keep", i, reg_control);
    end
    quiesce_cores();
  endtask

  task automatic test_one_shot();
    int c;
    int p;
    c = $urandom_range(num_cores - 1, 0);
    p = $urandom_range(40, 10);
    load_short_period(c, p);
    write_reg(c, reg_control, (16'd1 << ctrl_ito_bit) | (16'd1 << ctrl_start_bit));
    wait_cycles(p + 10);
    expect_timeout(c);
    read_check("oneshot", c, reg_status);
    check_irq("oneshot");
    write_reg(c, reg_status, 16'h0000);
    wait_cycles(2);
    check_irq("oneshot clear");
    read_check("oneshot clear", c, reg_status);
  endtask

  task automatic test_continuous();
    int c;
    int p;
    c = $urandom_range(num_cores - 1, 0);
    p = $urandom_range(40, 10);
    load_short_period(c, p);
    write_reg(c, reg_control, (16'd1 << ctrl_cont_bit) | (16'd1 << ctrl_start_bit));
    // one reload cycle per period on top of the count itself
    wait_cycles(3 * (p + 1) + 10);
    expect_timeout(c);
    read_check("cont", c, reg_status);
    write_reg(c, reg_control, 16'd1 << ctrl_stop_bit);
    read_check("cont stop", c, reg_status);
  endtask

  task automatic test_snapshot();
    int c;
    c = $urandom_range(num_cores - 1, 0);
    write_reg(c, reg_period_l, 16'($urandom));
    write_reg(c, reg_period_h, 16'($urandom));
    wait_cycles(2);
    write_reg(c, reg_snap_l, 16'h0000);
    read_check("snap", c, reg_snap_l);
    read_check("snap", c, reg_snap_h);
  endtask

  task automatic test_irq_chain();
    int k;
    int p;
    quiesce_cores();
    for (int c = 0; c < num_cores; c++)
      write_reg(c, reg_control, 16'd1 << ctrl_ito_bit);
    k = $urandom_range(num_cores - 2, 0);
    p = $urandom_range(40, 10);
    load_short_period(k, p);
    write_reg(k, reg_control, (16'd1 << ctrl_ito_bit) | (16'd1 << ctrl_start_bit));
    wait_cycles(p + 10);
    expect_timeout(k);
    read_all_status("chain");
    check_irq("chain");

    // now the bank's own chain input starts the ripple at core 0
    quiesce_cores();
    for (int c = 0; c < num_cores; c++)
      write_reg(c, reg_control, 16'd1 << ctrl_ito_bit);
    @(posedge clk);
    irq_chain_in <= 1'b1;
    chain_level = 1'b1;
    propagate_chain();
    wait_cycles(2);
    irq_chain_in <= 1'b0;
    chain_level = 1'b0;
    wait_cycles(num_cores + 2);
    read_all_status("chain in");
    check_irq("chain in");
  endtask

  // compare process
  initial
  begin : compare_results
    string       name;
    logic [15:0] exp_v;
    logic [15:0] act_v;
    forever
    begin
      @(sample_ev);
      while (act_q.size() > 0)
      begin
        name  = name_q.pop_front();
        exp_v = exp_q.pop_front();
        act_v = act_q.pop_front();
        checks++;
        assert (act_v === exp_v)
        else
        begin
          errors++;
          $display("** Error: %s expected 0x%04h actual 0x%04h", name, exp_v, act_v);
        end
      end
    end
  end

  initial
  begin : watchdog
    #(watchdog_cycles * clk_period);
    $display("timeout: run still busy after %0d cycles, %0d errors so far",
             watchdog_cycles, errors);
    $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin : main
    reset_n      = 1'b0;
    address      = '0;
    chipselect   = 1'b0;
    write_n      = 1'b1;
    writedata    = '0;
    irq_chain_in = 1'b0;
    chain_level  = 1'b0;
    void'($urandom(32'hbb50_d0b9));
    for (int c = 0; c < num_cores; c++)
    begin
      mdl_period_l[c] = `TIMER_RESET_PERIOD_L;
      mdl_period_h[c] = '0;
      mdl_ctrl[c]     = '0;
      mdl_flag[c]     = 1'b0;
      mdl_run[c]      = 1'b0;
      mdl_snap[c]     = '0;
    end
    wait_cycles(5);
    reset_n <= 1'b1;

    test_reset_values();
    test_register_access();
    test_one_shot();
    test_continuous();
    test_snapshot();
    test_irq_chain();

    // let the compare process drain the last results
    wait_cycles(2);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && checks > 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* timer_bank.f */
+incdir+design
design/timer_regs_pkg.sv
design/timer_count_pkg.sv
design/timer_counter.sv
design/timer_core.sv
design/timer_bank.sv
testbench/timer_bank_tb.sv

/* Bender.yml */
package:
  name: timer_bank

sources:
  # timer bank RTL, packages first
  - include_dirs:
      - design
    files:
      - design/timer_regs_pkg.sv
      - design/timer_count_pkg.sv
      - design/timer_counter.sv
      - design/timer_core.sv
      - design/timer_bank.sv

  # testbench, top module timer_bank_tb
  - target: test
    include_dirs:
      - design
    files:
      - testbench/timer_bank_tb.sv
